// ==== common/io_defs.svh ====
// address map, reset values and field widths of the io fabric, included by the rtl and testbench
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IO_ADDR_W 32
`define IO_DATA_W 32
`define IO_STRB_W 4
`define MTIME_W 64
`define DIV_FIELD_W 16 // each half of a divider register
`define CPU_FREQ_W 16 // q8.8 mhz

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define IO_WIN_START 32'h1000_0000 // inclusive
`define IO_WIN_END 32'h1200_0000 // inclusive
`define DIV_ADDR0 32'h1000_000C
`define DIV_ADDR1 32'h1000_0010
`define CPU_FREQ_ADDR 32'h1000_0014
`define MEM_SIZE_ADDR 32'h1000_0018

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset values and constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SYSTEM_CLK_HZ 50_000_000

// whole mhz of the system clock in q8.8, 16'h3200 at 50 mhz
`define CPU_FREQ_RESET 16'((`SYSTEM_CLK_HZ / 1_000_000) * 256)
`define CPU_FREQ_MIN 16'h0100 // 1.0 mhz
`define MEM_SIZE 32'h0200_0000
`define DIV_RESET 32'd1

`endif

// ==== common/io_map_pkg.sv ====
// register map types of the io fabric, imported by the decode stage and the register blocks
`include "io_defs.svh"

package io_map_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register select, result of the address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_DIV0,
    SEL_DIV1,
    SEL_CPU_FREQ,
    SEL_MEM_SIZE,
    SEL_UNMATCHED, // inside the window, no register
    SEL_FAULT // outside the window
  } reg_sel_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // divider register layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // div0 carries the spi rate in hi_div and the uart rate in lo_div,
  // div1 carries the mtime divider in lo_div
  typedef struct packed {
    logic [`DIV_FIELD_W-1:0] hi_div;
    logic [`DIV_FIELD_W-1:0] lo_div;
  } div_reg_t;

endpackage

// ==== common/io_bus_pkg.sv ====
// bus request, decoded request and response structs, imported by every pipeline stage
`include "io_defs.svh"

package io_bus_pkg;

  import io_map_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // master side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic valid; // held until ready
    logic [`IO_ADDR_W-1:0] addr;
    logic [`IO_STRB_W-1:0] wstrb; // any bit set means write
    logic [`IO_DATA_W-1:0] wdata;
  } bus_req_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // between stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic valid; // one cycle per accepted access
    logic is_write;
    reg_sel_t sel;
    logic [`IO_DATA_W-1:0] wdata;
  } dec_req_t;

  // response back to the master
  typedef struct packed {
    logic ready; // single cycle pulse
    logic fault; // access fault, data is zero
    logic [`IO_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

// ==== design/io_decode.sv ====
// decode stage of the io fabric: classifies the bus address and registers one access in flight
`timescale 1ns/1ps
`include "io_defs.svh"

module io_decode (
  input  logic                 clk,
  input  logic                 resetn,
  input  io_bus_pkg::bus_req_t bus_req_i,
  input  logic                 rsp_ready_i,
  output io_bus_pkg::dec_req_t dec_o
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  reg_sel_t sel;
  logic accept;
  logic busy_q; // access in flight, blocks the held request
  logic valid_q;
  logic is_write_q;
  reg_sel_t sel_q;
  logic [`IO_DATA_W-1:0] wdata_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address classification
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    sel = SEL_NONE;
    if (bus_req_i.addr == `DIV_ADDR0) begin
      sel = SEL_DIV0;
    end else if (bus_req_i.addr == `DIV_ADDR1) begin
      sel = SEL_DIV1;
    end else if (bus_req_i.addr == `CPU_FREQ_ADDR) begin
      sel = SEL_CPU_FREQ;
    end else if (bus_req_i.addr == `MEM_SIZE_ADDR) begin
      sel = SEL_MEM_SIZE;
    end else if (bus_req_i.addr >= `IO_WIN_START && bus_req_i.addr <= `IO_WIN_END) begin
      sel = SEL_UNMATCHED;
    end else begin
      sel = SEL_FAULT;
    end
  end

  assign accept = bus_req_i.valid && !busy_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rsp_ready_i) begin
        busy_q <= 1'b0; // master sees ready, may issue again
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      is_write_q <= |bus_req_i.wstrb;
      sel_q      <= sel;
      wdata_q    <= bus_req_i.wdata;
    end
  end

  always_comb begin
    dec_o.valid    = valid_q;
    dec_o.is_write = is_write_q;
    dec_o.sel      = sel_q;
    dec_o.wdata    = wdata_q;
  end

endmodule

// ==== clock_div/clk_div_regs.sv ====
// clock divider register pair, written and read through the decoded io request
`timescale 1ns/1ps
`include "io_defs.svh"

module clk_div_regs (
  input  logic                     clk,
  input  logic                     resetn,
  input  io_bus_pkg::dec_req_t     dec_i,
  output logic [`IO_DATA_W-1:0]    rdata_o,
  output io_map_pkg::div_reg_t     div1_o
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  div_reg_t div0_q; // spi and uart rates
  div_reg_t div1_q; // lo_div feeds the mtime prescaler
  logic wr_div0;
  logic wr_div1;

  assign wr_div0 = dec_i.valid && dec_i.is_write && (dec_i.sel == SEL_DIV0);
  assign wr_div1 = dec_i.valid && dec_i.is_write && (dec_i.sel == SEL_DIV1);

  // full word write, strobes are not used
  always_ff @(posedge clk) begin
    if (!resetn) begin
      div0_q <= `DIV_RESET;
      div1_q <= `DIV_RESET;
    end else begin
      if (wr_div0) begin
        div0_q <= dec_i.wdata;
      end
      if (wr_div1) begin
        div1_q <= dec_i.wdata;
      end
    end
  end

  always_comb begin
    case (dec_i.sel)
      SEL_DIV0: rdata_o = div0_q;
      SEL_DIV1: rdata_o = div1_q;
      default:  rdata_o = '0;
    endcase
  end

  assign div1_o = div1_q;

endmodule

// ==== clock_div/mtime_prescaler.sv ====
// mtime source: divides the external microsecond counter by the divider 1 low field
`timescale 1ns/1ps
`include "io_defs.svh"

module mtime_prescaler (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic [`MTIME_W-1:0]       timer_counter_i,
  input  logic [`DIV_FIELD_W-1:0]   mtime_div_i,
  output logic [`MTIME_W-1:0]       mtime_o
);

  logic [`MTIME_W-1:0] prev_q; // counter value at the last tick
  logic [`MTIME_W-1:0] mtime_div_q;
  logic [`MTIME_W-1:0] mtime_div_n;
  logic [`MTIME_W-1:0] mtime_q;
  logic [`DIV_FIELD_W-1:0] presc_q;
  logic [`DIV_FIELD_W-1:0] presc_n;
  logic [`DIV_FIELD_W-1:0] div_lat_q;
  logic [`DIV_FIELD_W-1:0] div_lat_n;
  logic [`DIV_FIELD_W-1:0] div_safe;
  logic tick;

  assign tick     = (timer_counter_i != prev_q);
  assign div_safe = (mtime_div_i == '0) ? `DIV_FIELD_W'(1) : mtime_div_i; // 0 acts as 1

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tick counting, the divider is relatched only at a wrap
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    presc_n     = presc_q;
    div_lat_n   = div_lat_q;
    mtime_div_n = mtime_div_q;
    if (tick) begin
      if (div_lat_q == `DIV_FIELD_W'(1)) begin
        presc_n   = '0;
        div_lat_n = div_safe;
      end else if (presc_q == div_lat_q - `DIV_FIELD_W'(1)) begin
        presc_n     = '0;
        mtime_div_n = mtime_div_q + `MTIME_W'(1);
        div_lat_n   = div_safe;
      end else begin
        presc_n = presc_q + `DIV_FIELD_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      prev_q      <= '0;
      presc_q     <= '0;
      div_lat_q   <= `DIV_FIELD_W'(1);
      mtime_div_q <= '0;
      mtime_q     <= '0;
    end else begin
      if (tick) begin
        prev_q <= timer_counter_i;
      end
      presc_q     <= presc_n;
      div_lat_q   <= div_lat_n;
      mtime_div_q <= mtime_div_n;
      mtime_q     <= (div_lat_n == `DIV_FIELD_W'(1)) ? timer_counter_i : mtime_div_n;
    end
  end

  assign mtime_o = mtime_q;

endmodule

// ==== design/sysinfo_regs.sv ====
// system info registers: writable cpu frequency in q8.8 and a read-only memory size
`timescale 1ns/1ps
`include "io_defs.svh"

module sysinfo_regs (
  input  logic                   clk,
  input  logic                   resetn,
  input  io_bus_pkg::dec_req_t   dec_i,
  output logic [`IO_DATA_W-1:0]  rdata_o,
  output logic [`CPU_FREQ_W-1:0] cpu_freq_o
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  logic [`CPU_FREQ_W-1:0] cpu_freq_q;
  logic [`CPU_FREQ_W-1:0] wr_freq;
  logic wr_cpu_freq;

  assign wr_cpu_freq = dec_i.valid && dec_i.is_write && (dec_i.sel == SEL_CPU_FREQ);

  // clamp to at least 1.0 mhz
  assign wr_freq = (dec_i.wdata[`CPU_FREQ_W-1:0] < `CPU_FREQ_MIN) ?
                   `CPU_FREQ_MIN : dec_i.wdata[`CPU_FREQ_W-1:0];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cpu_freq_q <= `CPU_FREQ_RESET;
    end else if (wr_cpu_freq) begin
      cpu_freq_q <= wr_freq;
    end
  end

  // mem size writes land here too and just complete
  always_comb begin
    case (dec_i.sel)
      SEL_CPU_FREQ: rdata_o = {{(`IO_DATA_W - `CPU_FREQ_W){1'b0}}, cpu_freq_q};
      SEL_MEM_SIZE: rdata_o = `MEM_SIZE;
      default:      rdata_o = '0;
    endcase
  end

  assign cpu_freq_o = cpu_freq_q;

endmodule

// ==== design/io_response.sv ====
// response stage: merges register read data, builds zero and fault responses, registers the result
`timescale 1ns/1ps
`include "io_defs.svh"

module io_response (
  input  logic                  clk,
  input  logic                  resetn,
  input  io_bus_pkg::dec_req_t  dec_i,
  input  logic [`IO_DATA_W-1:0] div_rdata_i,
  input  logic [`IO_DATA_W-1:0] sys_rdata_i,
  output io_bus_pkg::bus_rsp_t  rsp_o
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  logic [`IO_DATA_W-1:0] rdata_mux;
  logic ready_q;
  logic fault_q;
  logic [`IO_DATA_W-1:0] rdata_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read data merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rdata_mux = '0; // unmatched, fault and none
    if (!dec_i.is_write) begin
      case (dec_i.sel)
        SEL_DIV0, SEL_DIV1:         rdata_mux = div_rdata_i;
        SEL_CPU_FREQ, SEL_MEM_SIZE: rdata_mux = sys_rdata_i;
        default:                    rdata_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      ready_q <= dec_i.valid; // one pulse per access
      fault_q <= dec_i.valid && (dec_i.sel == SEL_FAULT);
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= dec_i.valid ? rdata_mux : '0;
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.fault = fault_q;
    rsp_o.rdata = rdata_q;
  end

endmodule

// ==== design/io_fabric_top.sv ====
// top of the io fabric: decode, register access and response stages plus the mtime prescaler
`timescale 1ns/1ps
`include "io_defs.svh"

module io_fabric_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  io_bus_pkg::bus_req_t   bus_req_i,
  output io_bus_pkg::bus_rsp_t   bus_rsp_o,
  input  logic [`MTIME_W-1:0]    timer_counter_i,
  output logic [`MTIME_W-1:0]    mtime_o,
  output logic [`CPU_FREQ_W-1:0] cpu_freq_q8_8_o
);

  import io_map_pkg::*;
  import io_bus_pkg::*;

  dec_req_t dec_q; // decoded access, valid one cycle
  logic [`IO_DATA_W-1:0] div_rdata;
  logic [`IO_DATA_W-1:0] sys_rdata;
  div_reg_t div1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  io_decode u_decode (
    .clk         (clk),
    .resetn      (resetn),
    .bus_req_i   (bus_req_i),
    .rsp_ready_i (bus_rsp_o.ready), // releases busy
    .dec_o       (dec_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register access stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  clk_div_regs u_clk_div (
    .clk     (clk),
    .resetn  (resetn),
    .dec_i   (dec_q),
    .rdata_o (div_rdata),
    .div1_o  (div1)
  );

  sysinfo_regs u_sysinfo (
    .clk        (clk),
    .resetn     (resetn),
    .dec_i      (dec_q),
    .rdata_o    (sys_rdata),
    .cpu_freq_o (cpu_freq_q8_8_o)
  );

  mtime_prescaler u_mtime (
    .clk             (clk),
    .resetn          (resetn),
    .timer_counter_i (timer_counter_i),
    .mtime_div_i     (div1.lo_div),
    .mtime_o         (mtime_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  io_response u_response (
    .clk         (clk),
    .resetn      (resetn),
    .dec_i       (dec_q),
    .div_rdata_i (div_rdata),
    .sys_rdata_i (sys_rdata),
    .rsp_o       (bus_rsp_o)
  );

endmodule

// ==== verification/io_fabric_properties.sv ====
// concurrent checks on the io fabric response stage, bound into io_response by the testbench
`timescale 1ns/1ps

module io_fabric_properties (
  input logic                 clk,
  input logic                 resetn,
  input io_bus_pkg::bus_rsp_t rsp_i
);

  int unsigned error_count = 0; // failed assertions so far

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ready_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
    rsp_i.ready |=> !rsp_i.ready)
    else begin
      error_count = error_count + 1;
      $error("ready high on two cycles in a row");
    end

  ready_low_in_reset: assert property (@(posedge clk) !resetn |=> !rsp_i.ready)
    else begin
      error_count = error_count + 1;
      $error("ready high after a reset cycle");
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fault responses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  fault_zero_data: assert property (@(posedge clk) disable iff (!resetn)
    rsp_i.fault |-> (rsp_i.rdata == '0))
    else begin
      error_count = error_count + 1;
      $error("fault response carries nonzero rdata");
    end

endmodule

// ==== verification/io_fabric_tb.sv ====
// testbench of the io fabric: directed and random bus accesses and mtime runs against a model
`timescale 1ns/1ps
`include "io_defs.svh"

module io_fabric_tb;

  import io_map_pkg::*;
  import io_bus_pkg::*;

  localparam int RSP_TIMEOUT = 20; // cycles from drive to ready

  logic clk;
  logic resetn;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic [`MTIME_W-1:0] timer_counter;
  logic [`MTIME_W-1:0] mtime;
  logic [`CPU_FREQ_W-1:0] cpu_freq;
  logic [`IO_DATA_W-1:0] div_model [2];
  logic [`CPU_FREQ_W-1:0] freq_model;
  logic [`MTIME_W-1:0] mtime_base; // divided count before a divider run

  io_fabric_top uut (
    .clk             (clk),
    .resetn          (resetn),
    .bus_req_i       (bus_req),
    .bus_rsp_o       (bus_rsp),
    .timer_counter_i (timer_counter),
    .mtime_o         (mtime),
    .cpu_freq_q8_8_o (cpu_freq)
  );

  bind io_response io_fabric_properties u_props (
    .clk    (clk),
    .resetn (resetn),
    .rsp_i  (rsp_o)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  always @(negedge clk) begin
    if (uut.u_response.u_props.error_count != 0) begin
      stop_on_error("a bound assertion on the response stage failed");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus master, called and returning on a falling edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data, input logic [31:0] exp_rdata,
                            input logic exp_fault);
    int cycles;
    cycles = 0;
    bus_req.valid = 1'b1;
    bus_req.addr  = addr;
    bus_req.wstrb = strb;
    bus_req.wdata = data;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > RSP_TIMEOUT) begin
        stop_on_error("bus ready did not arrive within the timeout");
      end
    end while (!bus_rsp.ready);
    check_value("bus_rsp_o.ready latency", cycles, 2); // accept edge plus two
    check_value("bus_rsp_o.rdata", bus_rsp.rdata, exp_rdata);
    check_value("bus_rsp_o.fault", bus_rsp.fault, exp_fault);
    bus_req.valid = 1'b0;
    @(negedge clk);
    check_value("bus_rsp_o.ready", bus_rsp.ready, 1'b0);
    check_value("cpu_freq_q8_8_o", cpu_freq, freq_model);
  endtask

  task automatic random_access();
    int kind;
    logic wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [3:0] strb;
    kind = $urandom % 6;
    wr   = $urandom % 2;
    data = $urandom;
    strb = wr ? 4'($urandom % 15 + 1) : 4'h0;
    exp  = '0;
    case (kind)
      0, 1: begin
        addr = (kind == 0) ? `DIV_ADDR0 : `DIV_ADDR1;
        if (wr) div_model[kind] = data;
        else exp = div_model[kind];
      end
      2: begin
        addr = `CPU_FREQ_ADDR;
        if ($urandom % 2) data[15:0] = 16'($urandom % 32'h200); // around the clamp
        if (wr) freq_model = (data[15:0] < `CPU_FREQ_MIN) ? `CPU_FREQ_MIN : data[15:0];
        else exp = {16'h0, freq_model};
      end
      3: begin
        addr = `MEM_SIZE_ADDR;
        if (!wr) exp = `MEM_SIZE;
      end
      4: addr = `IO_WIN_START + 32'h100 + ($urandom % 32'h1FF_FF00); // no register here
      default: addr = ($urandom % 2) ? ($urandom % `IO_WIN_START) :
                                       (`IO_WIN_END + 1 + ($urandom % 32'h1000_0000));
    endcase
    bus_access(addr, strb, data, exp, kind == 5);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mtime
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic change_counter(input logic [63:0] value);
    timer_counter = value;
    @(negedge clk);
  endtask

  task automatic check_follow(input int count);
    repeat (count) begin
      change_counter({$urandom, $urandom});
      check_value("mtime_o", mtime, timer_counter);
    end
  endtask

  task automatic divider_run(input int d);
    int m;
    m = 1 + $urandom % 4;
    div_model[1] = {16'($urandom), 16'(d)};
    bus_access(`DIV_ADDR1, 4'hF, div_model[1], '0, 1'b0);
    repeat (1 + m * d) change_counter(timer_counter + 1); // first tick latches d
    check_value("mtime_o", mtime, mtime_base + m);
    // the old divider completes one more period before 1 takes over
    div_model[1] = {div_model[1][31:16], 16'h0001};
    bus_access(`DIV_ADDR1, 4'hF, div_model[1], '0, 1'b0);
    repeat (d) change_counter(timer_counter + 1);
    mtime_base = mtime_base + m + 1;
    check_follow(3);
  endtask

  initial begin
    void'($urandom(32'h4055b9db));
    clk = 1'b0;
    resetn = 1'b0;
    bus_req = '0;
    timer_counter = '0;
    div_model[0] = `DIV_RESET;
    div_model[1] = `DIV_RESET;
    freq_model = `CPU_FREQ_RESET;
    mtime_base = '0;
    repeat (5) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    bus_access(`DIV_ADDR0, 4'h0, '0, `DIV_RESET, 1'b0); // reset values
    bus_access(`DIV_ADDR1, 4'h0, '0, `DIV_RESET, 1'b0);
    bus_access(`CPU_FREQ_ADDR, 4'h0, '0, 32'h0000_3200, 1'b0);
    bus_access(`MEM_SIZE_ADDR, 4'h0, '0, `MEM_SIZE, 1'b0);
    bus_access(`IO_WIN_START, 4'h0, '0, '0, 1'b0); // window edges
    bus_access(`IO_WIN_END, 4'hF, 32'hFFFF_FFFF, '0, 1'b0);
    bus_access(`IO_WIN_START - 1, 4'h0, '0, '0, 1'b1);
    bus_access(`IO_WIN_END + 1, 4'h3, 32'h1234_5678, '0, 1'b1);
    bus_access(`MEM_SIZE_ADDR, 4'hF, 32'hDEAD_BEEF, '0, 1'b0);
    bus_access(`MEM_SIZE_ADDR, 4'h0, '0, `MEM_SIZE, 1'b0);
    repeat (300) random_access();
    div_model[1] = {div_model[1][31:16], 16'h0000}; // 0 acts as 1
    bus_access(`DIV_ADDR1, 4'hF, div_model[1], '0, 1'b0);
    check_follow(4);
    for (int d = 2; d <= 5; d++) begin
      divider_run(d);
    end
    if (uut.u_response.u_props.error_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_on_error("a bound assertion on the response stage failed");
    end
  end

endmodule

// ==== sources.f ====
+incdir+common
common/io_map_pkg.sv
common/io_bus_pkg.sv
design/io_decode.sv
clock_div/clk_div_regs.sv
clock_div/mtime_prescaler.sv
design/sysinfo_regs.sv
design/io_response.sv
design/io_fabric_top.sv
verification/io_fabric_properties.sv
verification/io_fabric_tb.sv
